/* filelist.f */
hw/rx_link_pkg.sv
hw/rx_frame_parser.sv
hw/rx_frame_checker.sv
hw/rx_word_packer.sv
hw/rx_loss_monitor.sv
hw/tlk2711_rx_link.sv
dv/tb_tlk2711_rx_link.sv

/* Makefile */
TOOL      = verilator
TOP       = tb_tlk2711_rx_link
FILELIST  = filelist.f
FLAGS     = -sv --timing --timescale 1ns/1ps
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_tlk2711_rx_link.sv */
// runs with p_holdoff_cycles of 64; frames, noise and loss words are built here from a fixed seed
`timescale 1ns/1ps

module tb_tlk2711_rx_link;

    localparam int lp_holdoff      = 64;
    localparam int lp_good_frames  = 20;
    localparam int lp_num_frames   = 40;
    // sync, sof, head, header, 20 data words, checksum and a gap of up to 9
    localparam int lp_frame_words  = 40;
    localparam int lp_fixed_cycles = 16 + 6 * 64 + 600;
    localparam int lp_timeout      = 2 * (lp_num_frames * lp_frame_words + lp_fixed_cycles) + 1000;

    logic                       i_2711_rx_clk;
    logic                       i_reset;
    logic                       i_2711_rkmsb;
    logic                       i_2711_rklsb;
    rx_link_pkg::link_word_t    i_2711_rxd;
    logic                       i_link_loss_detect_ena;
    logic                       i_sync_loss_detect_ena;
    logic                       o_frame_done;
    rx_link_pkg::line_num_t     o_line_number;
    rx_link_pkg::frame_len_t    o_frame_length;
    rx_link_pkg::data_type_t    o_data_type;
    rx_link_pkg::chan_id_t      o_channel_id;
    logic                       o_file_end_flag;
    logic                       o_checksum_error;
    logic                       o_beat_valid;
    rx_link_pkg::beat_t         o_beat;
    logic                       o_link_loss;
    logic                       o_sync_loss;
    logic                       o_loss_interrupt;

    // expected results, one entry per frame or beat
    rx_link_pkg::line_num_t     exp_line_q[$];
    rx_link_pkg::frame_len_t    exp_len_q[$];
    rx_link_pkg::data_type_t    exp_type_q[$];
    rx_link_pkg::chan_id_t      exp_chan_q[$];
    logic                       exp_fe_q[$];
    logic                       exp_err_q[$];
    rx_link_pkg::beat_t         exp_beat_q[$];

    integer seed = 32'h6047708d;
    int     error_count = 0;
    int     test_count = 0;
    int     test_fail_count = 0;
    int     link_pulses = 0;
    int     sync_pulses = 0;
    int     irq_pulses = 0;

    tlk2711_rx_link #(
        .p_holdoff_cycles (lp_holdoff)
    ) i_tlk2711_rx_link (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_reset                (i_reset),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_frame_done           (o_frame_done),
        .o_line_number          (o_line_number),
        .o_frame_length         (o_frame_length),
        .o_data_type            (o_data_type),
        .o_channel_id           (o_channel_id),
        .o_file_end_flag        (o_file_end_flag),
        .o_checksum_error       (o_checksum_error),
        .o_beat_valid           (o_beat_valid),
        .o_beat                 (o_beat),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss),
        .o_loss_interrupt       (o_loss_interrupt)
    );

    initial begin
        i_2711_rx_clk = 1'b0;
        forever #10 i_2711_rx_clk = ~i_2711_rx_clk;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_header(
        input rx_link_pkg::line_num_t  got_line, input rx_link_pkg::line_num_t  exp_line,
        input rx_link_pkg::frame_len_t got_len,  input rx_link_pkg::frame_len_t exp_len,
        input rx_link_pkg::data_type_t got_type, input rx_link_pkg::data_type_t exp_type,
        input rx_link_pkg::chan_id_t   got_chan, input rx_link_pkg::chan_id_t   exp_chan,
        input logic                    got_fe,   input logic                    exp_fe
    );
        if ({got_line, got_len, got_type, got_chan, got_fe} !==
            {exp_line, exp_len, exp_type, exp_chan, exp_fe}) begin
            $display("ERROR %0t: header line %h len %0d type %h chan %0d end %b", $time,
                     got_line, got_len, got_type, got_chan, got_fe);
            $display("      expected line %h len %0d type %h chan %0d end %b",
                     exp_line, exp_len, exp_type, exp_chan, exp_fe);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %0s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_beat(input rx_link_pkg::beat_t got, input rx_link_pkg::beat_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: beat %h, expected %h", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERROR %0t: %0s counted %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge i_2711_rx_clk) begin
        if (!i_reset) begin
            if (o_frame_done) begin
                if (exp_line_q.size() == 0) begin
                    $display("frame_done at %0t while no frame was sent", $time);
                    error_count++;
                end else begin
                    check_header(o_line_number, exp_line_q.pop_front(),
                                 o_frame_length, exp_len_q.pop_front(),
                                 o_data_type, exp_type_q.pop_front(),
                                 o_channel_id, exp_chan_q.pop_front(),
                                 o_file_end_flag, exp_fe_q.pop_front());
                    check_flag(o_checksum_error, exp_err_q.pop_front(), "checksum error");
                end
            end
            if (o_beat_valid) begin
                if (exp_beat_q.size() == 0) begin
                    $display("beat at %0t while no payload beat was pending", $time);
                    error_count++;
                end else begin
                    check_beat(o_beat, exp_beat_q.pop_front());
                end
            end
            link_pulses = link_pulses + int'(o_link_loss);
            sync_pulses = sync_pulses + int'(o_sync_loss);
            irq_pulses  = irq_pulses + int'(o_loss_interrupt);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic drive_word(input logic k_msb, input logic k_lsb,
                              input rx_link_pkg::link_word_t word);
        @(posedge i_2711_rx_clk);
        i_2711_rkmsb <= k_msb;
        i_2711_rklsb <= k_lsb;
        i_2711_rxd   <= word;
    endtask

    // idle sync words or plain noise, never the first head word
    task automatic send_gap(input int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            if (rnd[16]) begin
                drive_word(1'b0, 1'b1, rx_link_pkg::c_sync_word);
            end else if (rnd[15:0] == rx_link_pkg::c_head_hi) begin
                drive_word(1'b0, 1'b0, 16'h0000);
            end else begin
                drive_word(1'b0, 1'b0, rnd[15:0]);
            end
        end
    endtask

    function automatic int rand_len();
        logic [31:0] rnd;
        rnd = $random(seed);
        return 2 + 2 * int'(rnd % 32'd20);
    endfunction

    // k_at marks one data word that carries a K bit, -1 for none
    task automatic send_frame(input int len_bytes, input logic bad_sum, input int k_at);
        logic [31:0]             rnd;
        rx_link_pkg::link_word_t type_w;
        rx_link_pkg::link_word_t len_w;
        rx_link_pkg::link_word_t sum;
        rx_link_pkg::beat_t      beat;
        int                      lane;
        rnd    = $random(seed);
        type_w = {rnd[31:30], rnd[29:28], rnd[27:24], rnd[23:16]};
        len_w  = 16'(len_bytes);
        exp_line_q.push_back(rnd[23:0]);
        exp_len_q.push_back(len_w);
        exp_type_q.push_back(rnd[27:24]);
        exp_chan_q.push_back(rnd[29:28]);
        exp_fe_q.push_back(rnd[30]);
        exp_err_q.push_back(bad_sum);
        drive_word(1'b0, 1'b1, rx_link_pkg::c_sync_word);
        drive_word(1'b1, 1'b1, rx_link_pkg::c_sof_word);
        drive_word(1'b0, 1'b0, rx_link_pkg::c_head_hi);
        drive_word(1'b0, 1'b0, rx_link_pkg::c_head_lo);
        drive_word(1'b0, 1'b0, type_w);
        drive_word(1'b0, 1'b0, rnd[15:0]);
        drive_word(1'b0, 1'b0, len_w);
        sum  = type_w + rnd[15:0] + len_w;
        beat = '0;
        lane = 0;
        for (int i = 0; i < len_bytes / 2; i++) begin
            rnd  = $random(seed);
            sum  = sum + rnd[15:0];
            // newest word enters at the top, so word 0 ends in the low lane
            beat = {rnd[15:0], beat[63:16]};
            lane++;
            if (lane == 4) begin
                exp_beat_q.push_back(beat);
                lane = 0;
            end
            drive_word(1'b0, (i == k_at), rnd[15:0]);
        end
        if (lane != 0) begin
            while (lane != 4) begin
                beat = {16'h0000, beat[63:16]};
                lane++;
            end
            exp_beat_q.push_back(beat);
        end
        drive_word(1'b0, 1'b0, bad_sum ? sum + 16'h0101 : sum);
        rnd = $random(seed);
        send_gap(2 + int'(rnd[2:0]));
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_line_q.size() != 0 || exp_beat_q.size() != 0) && waited < 64) begin
            @(posedge i_2711_rx_clk);
            waited++;
        end
        if (exp_line_q.size() != 0 || exp_beat_q.size() != 0) begin
            $display("at %0t, %0d frames and %0d beats never came out of the DUT",
                     $time, exp_line_q.size(), exp_beat_q.size());
            error_count++;
            exp_line_q.delete();
            exp_len_q.delete();
            exp_type_q.delete();
            exp_chan_q.delete();
            exp_fe_q.delete();
            exp_err_q.delete();
            exp_beat_q.delete();
        end
        send_gap(4);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0s: pass", name);
        end else begin
            test_fail_count++;
            $display("test %0s: fail with %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int err0;
        int link0;
        int sync0;
        int irq0;
        int lens[11];
        i_reset                = 1'b1;
        i_2711_rkmsb           = 1'b0;
        i_2711_rklsb           = 1'b0;
        i_2711_rxd             = '0;
        i_link_loss_detect_ena = 1'b0;
        i_sync_loss_detect_ena = 1'b0;
        lens = '{2, 4, 6, 8, 10, 12, 14, 16, 18, 34, 40};
        repeat (16) @(posedge i_2711_rx_clk);
        i_reset                <= 1'b0;
        i_link_loss_detect_ena <= 1'b1;
        i_sync_loss_detect_ena <= 1'b1;

        err0 = error_count;
        @(negedge i_2711_rx_clk);
        check_flag(o_frame_done, 1'b0, "frame_done after reset");
        check_flag(o_beat_valid, 1'b0, "beat_valid after reset");
        check_header(o_line_number, '0, o_frame_length, '0, o_data_type, '0,
                     o_channel_id, '0, o_file_end_flag, 1'b0);
        for (int i = 0; i < lp_good_frames; i++) begin
            send_frame(rand_len(), 1'b0, -1);
        end
        wait_drain();
        check_count(link_pulses + sync_pulses + irq_pulses, 0, "loss pulses during good frames");
        finish_test("good frames", err0);

        err0 = error_count;
        send_frame(rand_len(), 1'b1, -1);
        send_frame(rand_len(), 1'b0, -1);
        send_frame(rand_len(), 1'b1, -1);
        send_frame(rand_len(), 1'b0, -1);
        wait_drain();
        finish_test("checksum error", err0);

        err0 = error_count;
        foreach (lens[i]) begin
            send_frame(lens[i], 1'b0, -1);
        end
        wait_drain();
        finish_test("payload beats", err0);

        // wrong frame start, then wrong head flag, then plain noise
        err0 = error_count;
        drive_word(1'b0, 1'b1, rx_link_pkg::c_sync_word);
        drive_word(1'b1, 1'b1, 16'h5CFC);
        send_gap(3);
        send_frame(rand_len(), 1'b0, -1);
        drive_word(1'b0, 1'b1, rx_link_pkg::c_sync_word);
        drive_word(1'b1, 1'b1, rx_link_pkg::c_sof_word);
        drive_word(1'b0, 1'b0, rx_link_pkg::c_head_hi);
        drive_word(1'b0, 1'b0, 16'hE117);
        send_gap(3);
        send_frame(rand_len(), 1'b0, -1);
        send_gap(20);
        send_frame(rand_len(), 1'b0, -1);
        wait_drain();
        finish_test("false starts", err0);

        // second word 62 cycles after the first, third 68 cycles after the first
        err0  = error_count;
        link0 = link_pulses;
        irq0  = irq_pulses;
        drive_word(1'b1, 1'b1, rx_link_pkg::c_link_loss_word);
        send_gap(61);
        drive_word(1'b1, 1'b1, rx_link_pkg::c_link_loss_word);
        send_gap(5);
        drive_word(1'b1, 1'b1, rx_link_pkg::c_link_loss_word);
        send_gap(8);
        check_count(link_pulses - link0, 2, "link loss pulses");
        check_count(irq_pulses - irq0, 2, "loss interrupts");
        link0 = link_pulses;
        @(posedge i_2711_rx_clk);
        i_link_loss_detect_ena <= 1'b0;
        drive_word(1'b1, 1'b1, rx_link_pkg::c_link_loss_word);
        send_gap(80);
        drive_word(1'b1, 1'b1, rx_link_pkg::c_link_loss_word);
        send_gap(8);
        check_count(link_pulses - link0, 0, "link loss pulses while disabled");
        i_link_loss_detect_ena <= 1'b1;
        finish_test("link loss", err0);

        err0  = error_count;
        sync0 = sync_pulses;
        irq0  = irq_pulses;
        send_frame(16, 1'b0, 3);
        wait_drain();
        check_count(sync_pulses - sync0, 1, "sync loss pulses");
        check_count(irq_pulses - irq0, 1, "loss interrupts on sync loss");
        send_gap(80);
        sync0 = sync_pulses;
        drive_word(1'b1, 1'b0, 16'h1234);
        drive_word(1'b0, 1'b1, 16'h4321);
        send_gap(8);
        check_count(sync_pulses - sync0, 0, "sync loss pulses outside a frame");
        finish_test("sync loss", err0);

        $display("tests %0d, failed %0d, errors %0d", test_count, test_fail_count, error_count);
        if (error_count == 0 && test_fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(lp_timeout * 20);
        $display("watchdog expired after %0d cycles before the tests finished", lp_timeout);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* hw/tlk2711_rx_link.sv */
// single rx clock, no back-pressure; beats and frame_done must be taken when they pulse
`timescale 1ns/1ps

module tlk2711_rx_link #(
    parameter int unsigned p_holdoff_cycles = 10000000
) (
    input  logic                       i_2711_rx_clk,
    input  logic                       i_reset,
    input  logic                       i_2711_rkmsb,
    input  logic                       i_2711_rklsb,
    input  rx_link_pkg::link_word_t    i_2711_rxd,
    input  logic                       i_link_loss_detect_ena,
    input  logic                       i_sync_loss_detect_ena,
    output logic                       o_frame_done,
    output rx_link_pkg::line_num_t     o_line_number,
    output rx_link_pkg::frame_len_t    o_frame_length,
    output rx_link_pkg::data_type_t    o_data_type,
    output rx_link_pkg::chan_id_t      o_channel_id,
    output logic                       o_file_end_flag,
    output logic                       o_checksum_error,
    output logic                       o_beat_valid,
    output rx_link_pkg::beat_t         o_beat,
    output logic                       o_link_loss,
    output logic                       o_sync_loss,
    output logic                       o_loss_interrupt
);

    rx_link_pkg::link_word_t word;
    rx_link_pkg::rx_phase_t  phase;
    logic                    in_frame;

    rx_frame_parser u_parser (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_reset       (i_reset),
        .i_2711_rkmsb  (i_2711_rkmsb),
        .i_2711_rklsb  (i_2711_rklsb),
        .i_2711_rxd    (i_2711_rxd),
        .o_word        (word),
        .o_phase       (phase),
        .o_in_frame    (in_frame)
    );

    rx_frame_checker u_checker (
        .i_2711_rx_clk    (i_2711_rx_clk),
        .i_reset          (i_reset),
        .i_word           (word),
        .i_phase          (phase),
        .o_frame_done     (o_frame_done),
        .o_line_number    (o_line_number),
        .o_frame_length   (o_frame_length),
        .o_data_type      (o_data_type),
        .o_channel_id     (o_channel_id),
        .o_file_end_flag  (o_file_end_flag),
        .o_checksum_error (o_checksum_error)
    );

    rx_word_packer u_packer (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_reset       (i_reset),
        .i_word        (word),
        .i_phase       (phase),
        .o_beat_valid  (o_beat_valid),
        .o_beat        (o_beat)
    );

    // watches the raw input, not the registered word
    rx_loss_monitor #(
        .p_holdoff_cycles (p_holdoff_cycles)
    ) u_loss_monitor (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_reset                (i_reset),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_in_frame             (in_frame),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss)
    );

    assign o_loss_interrupt = o_link_loss | o_sync_loss;

endmodule

/* hw/rx_loss_monitor.sv */
// hold-off counter is 24 bits, so p_holdoff_cycles must stay below 2**24
`timescale 1ns/1ps

module rx_loss_monitor #(
    parameter int unsigned p_holdoff_cycles = 10000000
) (
    input  logic                       i_2711_rx_clk,
    input  logic                       i_reset,
    input  logic                       i_2711_rkmsb,
    input  logic                       i_2711_rklsb,
    input  rx_link_pkg::link_word_t    i_2711_rxd,
    input  logic                       i_in_frame,
    input  logic                       i_link_loss_detect_ena,
    input  logic                       i_sync_loss_detect_ena,
    output logic                       o_link_loss,
    output logic                       o_sync_loss
);

    localparam logic [23:0] lp_holdoff = 24'(p_holdoff_cycles);

    // index 0 is link loss, index 1 is sync loss
    logic [1:0] loss_evt;
    logic [1:0] loss_ena;
    logic [1:0] loss_pulse;

    assign loss_evt[0] = i_2711_rkmsb & i_2711_rklsb &
                         (i_2711_rxd == rx_link_pkg::c_link_loss_word);
    // any K code inside type..checksum breaks the frame
    assign loss_evt[1] = (i_2711_rkmsb | i_2711_rklsb) & i_in_frame;
    assign loss_ena    = {i_sync_loss_detect_ena, i_link_loss_detect_ena};

    ////////////////////////////////////////
    // one detector per loss kind
    ////////////////////////////////////////

    for (genvar g = 0; g < 2; g++) begin : g_det
        logic        pulse_q;
        logic        hold_flag;
        logic [23:0] hold_cnt;

        always_ff @(posedge i_2711_rx_clk) begin
            if (i_reset || !loss_ena[g]) begin
                pulse_q   <= 1'b0;
                hold_flag <= 1'b0;
                hold_cnt  <= '0;
            end else begin
                // pulse_q also blocks an event right behind the first
                pulse_q <= loss_evt[g] & ~hold_flag & ~pulse_q;
                if (pulse_q) begin
                    hold_flag <= 1'b1;
                end else if (hold_cnt == lp_holdoff) begin
                    hold_flag <= 1'b0;
                end
                if (hold_flag) begin
                    hold_cnt <= hold_cnt + 24'd1;
                end else begin
                    hold_cnt <= '0;
                end
            end
        end

        assign loss_pulse[g] = pulse_q;
    end

    assign o_link_loss = loss_pulse[0];
    assign o_sync_loss = loss_pulse[1];

endmodule

/* hw/rx_word_packer.sv */
// word k of a beat lands in bits 16k+15:16k; a partial last beat leaves with the checksum word
`timescale 1ns/1ps

module rx_word_packer (
    input  logic                       i_2711_rx_clk,
    input  logic                       i_reset,
    input  rx_link_pkg::link_word_t    i_word,
    input  rx_link_pkg::rx_phase_t     i_phase,
    output logic                       o_beat_valid,
    output rx_link_pkg::beat_t         o_beat
);

    logic [1:0]          lane;
    rx_link_pkg::beat_t  asm_beat;
    logic                is_data;
    logic                is_flush;

    assign is_data  = (i_phase == rx_link_pkg::ph_data);
    // a partial beat is pending when lanes were filled
    assign is_flush = (i_phase == rx_link_pkg::ph_checksum) & (lane != 2'd0);

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_reset) begin
            lane         <= 2'd0;
            o_beat_valid <= 1'b0;
        end else begin
            o_beat_valid <= (is_data & (lane == 2'd3)) | is_flush;
            if (is_data) begin
                lane <= lane + 2'd1;
            end else if (i_phase == rx_link_pkg::ph_type || i_phase == rx_link_pkg::ph_checksum) begin
                lane <= 2'd0;
            end
        end
    end

    // unfilled lanes stay zero, that is the padding
    always_ff @(posedge i_2711_rx_clk) begin
        if (is_data && lane == 2'd3) begin
            o_beat   <= {i_word, asm_beat[47:0]};
            asm_beat <= '0;
        end else if (is_data) begin
            asm_beat[{lane, 4'b0000} +: 16] <= i_word;
        end else if (i_phase == rx_link_pkg::ph_type || i_phase == rx_link_pkg::ph_checksum) begin
            o_beat   <= asm_beat;
            asm_beat <= '0;
        end
    end

endmodule

/* hw/rx_frame_checker.sv */
// header outputs change only with o_frame_done; checksum is the 16-bit wrapping sum
`timescale 1ns/1ps

module rx_frame_checker (
    input  logic                       i_2711_rx_clk,
    input  logic                       i_reset,
    input  rx_link_pkg::link_word_t    i_word,
    input  rx_link_pkg::rx_phase_t     i_phase,
    output logic                       o_frame_done,
    output rx_link_pkg::line_num_t     o_line_number,
    output rx_link_pkg::frame_len_t    o_frame_length,
    output rx_link_pkg::data_type_t    o_data_type,
    output rx_link_pkg::chan_id_t      o_channel_id,
    output logic                       o_file_end_flag,
    output logic                       o_checksum_error
);

    rx_link_pkg::link_word_t   sum;
    rx_link_pkg::line_num_t    sh_line;
    rx_link_pkg::frame_len_t   sh_length;
    rx_link_pkg::data_type_t   sh_type;
    rx_link_pkg::chan_id_t     sh_channel;
    logic                      sh_file_end;

    // running sum and header shadows, restarted by every type word
    always_ff @(posedge i_2711_rx_clk) begin
        case (i_phase)
            rx_link_pkg::ph_type: begin
                sum            <= i_word;
                sh_file_end    <= i_word[14];
                sh_channel     <= i_word[13:12];
                sh_type        <= i_word[11:8];
                sh_line[23:16] <= i_word[7:0];
            end
            rx_link_pkg::ph_line: begin
                sum           <= sum + i_word;
                sh_line[15:0] <= i_word;
            end
            rx_link_pkg::ph_length: begin
                sum       <= sum + i_word;
                sh_length <= i_word;
            end
            rx_link_pkg::ph_data: sum <= sum + i_word;
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // publish at the checksum word
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_reset) begin
            o_frame_done     <= 1'b0;
            o_line_number    <= '0;
            o_frame_length   <= '0;
            o_data_type      <= '0;
            o_channel_id     <= '0;
            o_file_end_flag  <= 1'b0;
            o_checksum_error <= 1'b0;
        end else begin
            o_frame_done <= (i_phase == rx_link_pkg::ph_checksum);
            if (i_phase == rx_link_pkg::ph_checksum) begin
                o_line_number    <= sh_line;
                o_frame_length   <= sh_length;
                o_data_type      <= sh_type;
                o_channel_id     <= sh_channel;
                o_file_end_flag  <= sh_file_end;
                o_checksum_error <= (sum != i_word);
            end
        end
    end

endmodule

/* hw/rx_frame_parser.sv */
// never aborts a frame once the head flag matched; length must be even and at least 2
`timescale 1ns/1ps

module rx_frame_parser (
    input  logic                       i_2711_rx_clk,
    input  logic                       i_reset,
    input  logic                       i_2711_rkmsb,
    input  logic                       i_2711_rklsb,
    input  rx_link_pkg::link_word_t    i_2711_rxd,
    output rx_link_pkg::link_word_t    o_word,
    output rx_link_pkg::rx_phase_t     o_phase,
    output logic                       o_in_frame
);

    rx_link_pkg::parser_state_t state;
    rx_link_pkg::parser_state_t state_nxt;
    rx_link_pkg::rx_phase_t     phase_now;
    rx_link_pkg::link_word_t    prev_word;
    // data words still to come after the current one
    logic [14:0]                data_left;
    logic                       is_sync;
    logic                       is_sof;
    logic                       is_head;

    assign is_sync = ~i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == rx_link_pkg::c_sync_word);
    assign is_sof  = i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == rx_link_pkg::c_sof_word);
    assign is_head = (prev_word == rx_link_pkg::c_head_hi) &
                     (i_2711_rxd == rx_link_pkg::c_head_lo);

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            rx_link_pkg::st_idle:     if (is_sync) state_nxt = rx_link_pkg::st_sync;
            rx_link_pkg::st_sync:     if (is_sof) state_nxt = rx_link_pkg::st_head;
            rx_link_pkg::st_head:     if (is_head) state_nxt = rx_link_pkg::st_type;
            rx_link_pkg::st_type:     state_nxt = rx_link_pkg::st_line;
            rx_link_pkg::st_line:     state_nxt = rx_link_pkg::st_length;
            rx_link_pkg::st_length:   state_nxt = rx_link_pkg::st_data;
            rx_link_pkg::st_data:     if (data_left == '0) state_nxt = rx_link_pkg::st_checksum;
            rx_link_pkg::st_checksum: state_nxt = rx_link_pkg::st_end1;
            rx_link_pkg::st_end1:     state_nxt = rx_link_pkg::st_end2;
            default:                  state_nxt = rx_link_pkg::st_idle;
        endcase
    end

    // phase of the word sampled in this cycle
    always_comb begin
        case (state)
            rx_link_pkg::st_type:     phase_now = rx_link_pkg::ph_type;
            rx_link_pkg::st_line:     phase_now = rx_link_pkg::ph_line;
            rx_link_pkg::st_length:   phase_now = rx_link_pkg::ph_length;
            rx_link_pkg::st_data:     phase_now = rx_link_pkg::ph_data;
            rx_link_pkg::st_checksum: phase_now = rx_link_pkg::ph_checksum;
            default:                  phase_now = rx_link_pkg::ph_none;
        endcase
    end

    assign o_in_frame = (phase_now != rx_link_pkg::ph_none);

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_reset) begin
            state   <= rx_link_pkg::st_idle;
            o_phase <= rx_link_pkg::ph_none;
        end else begin
            state   <= state_nxt;
            o_phase <= phase_now;
        end
    end

    ////////////////////////////////////////
    // word pipe and data counter
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        prev_word <= i_2711_rxd;
        o_word    <= i_2711_rxd;
        if (state == rx_link_pkg::st_length) begin
            // length in bytes, two bytes per word
            data_left <= i_2711_rxd[15:1] - 15'd1;
        end else if (state == rx_link_pkg::st_data) begin
            data_left <= data_left - 15'd1;
        end
    end

endmodule

/* hw/rx_link_pkg.sv */
// shared link word types and codes; K bits travel beside the word and are not part of it
package rx_link_pkg;

    ////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////

    typedef logic [15:0] link_word_t;
    typedef logic [63:0] beat_t;
    typedef logic [23:0] line_num_t;
    // payload length in bytes, always even
    typedef logic [15:0] frame_len_t;
    typedef logic [1:0]  chan_id_t;
    typedef logic [3:0]  data_type_t;

    ////////////////////////////////////////
    // link codes
    ////////////////////////////////////////

    // D5.6 + K28.5, only lsb K bit set
    localparam link_word_t c_sync_word      = 16'hC5BC;
    // K28.2 + K27.7, both K bits set
    localparam link_word_t c_sof_word       = 16'h5CFB;
    // two-word head flag after the frame start
    localparam link_word_t c_head_hi        = 16'hEB90;
    localparam link_word_t c_head_lo        = 16'hE116;
    // idle fill from the serdes when the link drops
    localparam link_word_t c_link_loss_word = 16'hFFFF;

    ////////////////////////////////////////
    // frame phase and parser states
    ////////////////////////////////////////

    // tag carried with each registered word
    typedef enum logic [2:0] {
        ph_none,
        ph_type,
        ph_line,
        ph_length,
        ph_data,
        ph_checksum
    } rx_phase_t;

    typedef enum logic [3:0] {
        st_idle,
        st_sync,
        st_head,
        st_type,
        st_line,
        st_length,
        st_data,
        st_checksum,
        st_end1,
        st_end2
    } parser_state_t;

endpackage
